/* verilog/riscv_div_pkg.sv */
`default_nettype none

package riscv_div_pkg;

  // ~~~~~~~~~~~~~~~~~~~~
  // operation encoding
  // ~~~~~~~~~~~~~~~~~~~~

  // with the word flag set these same codes are DIVW, DIVUW, REMW and REMUW
  typedef enum logic [1:0]
  {
    DIV  = 2'b00,
    DIVU = 2'b01,
    REM  = 2'b10,
    REMU = 2'b11
  } div_op_e;

  // control half of a request
  typedef struct packed
  {
    div_op_e op;
    logic    isword;
  } div_ctrl_t;

  // facts about the effective operands, signs stay zero for unsigned ops
  typedef struct packed
  {
    logic a_neg;
    logic b_neg;
    logic b_zero;
    logic ovf;
  } div_sign_t;

  // ~~~~~~~~~~~~~~~~~~~~
  // op decode helpers
  // ~~~~~~~~~~~~~~~~~~~~

  function automatic logic op_is_signed(input div_op_e op);
    return (op == DIV) || (op == REM);
  endfunction

  function automatic logic op_is_rem(input div_op_e op);
    return (op == REM) || (op == REMU);
  endfunction

endpackage

`default_nettype wire

/* verilog/riscv_core_div_in.sv */
`timescale 1ns/10ps
`default_nettype none

module riscv_core_div_in
#(
  parameter int XLEN = 64
)
(
  input  logic                      i_div_out_clk,
  input  logic                      i_div_out_rstn,
  input  logic                      i_start,
  input  riscv_div_pkg::div_ctrl_t  i_ctrl,
  input  logic [XLEN-1:0]           i_src_a,
  input  logic [XLEN-1:0]           i_src_b,
  input  logic                      i_done,
  output logic                      o_busy,
  output logic                      o_go,
  output logic [XLEN-1:0]           o_dividend_mag,
  output logic [XLEN-1:0]           o_divisor_mag,
  output logic [$clog2(XLEN+1)-1:0] o_iter_cnt,
  output riscv_div_pkg::div_ctrl_t  o_ctrl,
  output riscv_div_pkg::div_sign_t  o_sign,
  output logic [XLEN-1:0]           o_src_a_eff
);

  import riscv_div_pkg::*;

  localparam int CNT_W = $clog2(XLEN+1);
  // a word is 32 bits, which is already the full width on a 32-bit core
  localparam int WLEN = (XLEN > 32) ? 32 : XLEN;
  localparam logic [XLEN-1:0] WORD_MASK = {XLEN{1'b1}} >> (XLEN - WLEN);
  localparam logic [XLEN-1:0] ONE = {{(XLEN-1){1'b0}}, 1'b1};
  localparam logic [XLEN-1:0] XLEN_MIN = ONE << (XLEN - 1);
  localparam logic [XLEN-1:0] WORD_MIN = ~WORD_MASK | (ONE << (WLEN - 1));

  logic             busy;
  logic             accept;
  logic             signed_op;
  logic [XLEN-1:0]  a_eff;
  logic [XLEN-1:0]  b_eff;
  logic [CNT_W-1:0] cnt_d;
  div_sign_t        sign_d;

  logic             busy_q;
  logic             go_q;
  div_ctrl_t        ctrl_q;
  div_sign_t        sign_q;
  logic [XLEN-1:0]  a_eff_q;
  logic [XLEN-1:0]  a_mag_q;
  logic [XLEN-1:0]  b_mag_q;
  logic [CNT_W-1:0] cnt_q;

  // busy drops together with the done strobe
  assign busy      = busy_q && !i_done;
  // a strobe seen while busy is dropped
  assign accept    = i_start && !busy;
  assign signed_op = op_is_signed(i_ctrl.op);

  always_comb
  begin
    a_eff = i_src_a;
    b_eff = i_src_b;
    cnt_d = CNT_W'(XLEN);
    if (i_ctrl.isword)
    begin
      a_eff = i_src_a & WORD_MASK;
      b_eff = i_src_b & WORD_MASK;
      cnt_d = CNT_W'(WLEN);
      if (signed_op && i_src_a[WLEN-1])
      begin
        a_eff = a_eff | ~WORD_MASK;
      end
      if (signed_op && i_src_b[WLEN-1])
      begin
        b_eff = b_eff | ~WORD_MASK;
      end
    end
  end

  always_comb
  begin
    sign_d.a_neg  = signed_op && a_eff[XLEN-1];
    sign_d.b_neg  = signed_op && b_eff[XLEN-1];
    sign_d.b_zero = (b_eff == '0);
    // most negative dividend over minus one
    sign_d.ovf    = signed_op && (&b_eff) &&
                    (a_eff == (i_ctrl.isword ? WORD_MIN : XLEN_MIN));
  end

  always_ff @(posedge i_div_out_clk, negedge i_div_out_rstn)
  begin
    if (!i_div_out_rstn)
    begin
      busy_q <= 1'b0;
      go_q   <= 1'b0;
      ctrl_q <= '0;
      sign_q <= '0;
    end
    else
    begin
      go_q <= accept;
      if (accept)
      begin
        busy_q <= 1'b1;
        ctrl_q <= i_ctrl;
        sign_q <= sign_d;
      end
      else if (i_done)
      begin
        busy_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge i_div_out_clk)
  begin
    if (accept)
    begin
      a_eff_q <= a_eff;
      a_mag_q <= sign_d.a_neg ? (~a_eff + ONE) : a_eff;
      b_mag_q <= sign_d.b_neg ? (~b_eff + ONE) : b_eff;
      cnt_q   <= cnt_d;
    end
  end

  assign o_busy         = busy;
  assign o_go           = go_q;
  assign o_ctrl         = ctrl_q;
  assign o_sign         = sign_q;
  assign o_src_a_eff    = a_eff_q;
  assign o_dividend_mag = a_mag_q;
  assign o_divisor_mag  = b_mag_q;
  assign o_iter_cnt     = cnt_q;

endmodule

`default_nettype wire

/* verilog/riscv_core_div_core.sv */
`timescale 1ns/10ps
`default_nettype none

module riscv_core_div_core
#(
  parameter int XLEN = 64
)
(
  input  logic                      i_div_out_clk,
  input  logic                      i_div_out_rstn,
  input  logic                      i_go,
  input  logic [XLEN-1:0]           i_dividend_mag,
  input  logic [XLEN-1:0]           i_divisor_mag,
  input  logic [$clog2(XLEN+1)-1:0] i_iter_cnt,
  output logic                      o_fin,
  output logic [XLEN-1:0]           o_quotient,
  output logic [XLEN-1:0]           o_remainder
);

  localparam int CNT_W = $clog2(XLEN+1);

  logic             run_q;
  logic             fin_q;
  logic [CNT_W-1:0] cnt_q;

  // quo_q starts as the dividend and fills with quotient bits from the bottom
  logic [XLEN-1:0]  quo_q;
  logic [XLEN-1:0]  rem_q;
  logic [XLEN-1:0]  dvs_q;

  logic [CNT_W-1:0] pre_shift;
  logic             step;
  logic [XLEN:0]    rem_shift;
  logic [XLEN:0]    rem_diff;
  logic             q_bit;

  // ~~~~~~~~~~~~~~~~~~~~
  // one restoring step
  // ~~~~~~~~~~~~~~~~~~~~

  // a short operation starts with its top bit in the MSB of quo_q
  assign pre_shift = CNT_W'(XLEN) - i_iter_cnt;

  assign step      = run_q && (cnt_q != '0);
  assign rem_shift = {rem_q, quo_q[XLEN-1]};
  assign rem_diff  = rem_shift - {1'b0, dvs_q};

  // no borrow means the divisor fits and the quotient bit is one
  assign q_bit     = ~rem_diff[XLEN];

  // ~~~~~~~~~~~~~~~~~~~~
  // sequencing
  // ~~~~~~~~~~~~~~~~~~~~

  always_ff @(posedge i_div_out_clk, negedge i_div_out_rstn)
  begin
    if (!i_div_out_rstn)
    begin
      run_q <= 1'b0;
      fin_q <= 1'b0;
      cnt_q <= '0;
    end
    else
    begin
      fin_q <= 1'b0;
      if (i_go)
      begin
        run_q <= 1'b1;
        cnt_q <= i_iter_cnt;
      end
      else if (run_q)
      begin
        if (cnt_q == '0)
        begin
          // all bits done, flag the result for one cycle
          run_q <= 1'b0;
          fin_q <= 1'b1;
        end
        else
        begin
          cnt_q <= cnt_q - 1'b1;
        end
      end
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~
  // datapath
  // ~~~~~~~~~~~~~~~~~~~~

  always_ff @(posedge i_div_out_clk)
  begin
    if (i_go)
    begin
      quo_q <= i_dividend_mag << pre_shift;
      rem_q <= '0;
      dvs_q <= i_divisor_mag;
    end
    else if (step)
    begin
      quo_q <= {quo_q[XLEN-2:0], q_bit};
      rem_q <= q_bit ? rem_diff[XLEN-1:0] : rem_shift[XLEN-1:0];
    end
  end

  // bits shifted out of a short operation leave zeros above the quotient
  assign o_fin       = fin_q;
  assign o_quotient  = quo_q;
  assign o_remainder = rem_q;

endmodule

`default_nettype wire

/* verilog/riscv_core_div_out.sv */
`timescale 1ns/10ps
`default_nettype none

module riscv_core_div_out
#(
  parameter int XLEN = 64
)
(
  input  logic                     i_div_out_clk,
  input  logic                     i_div_out_rstn,
  input  logic                     i_div_out_done,
  input  logic [XLEN-1:0]          i_div_out_quotient,
  input  logic [XLEN-1:0]          i_div_out_remainder,
  input  riscv_div_pkg::div_ctrl_t i_div_out_ctrl,
  input  riscv_div_pkg::div_sign_t i_div_out_sign,
  input  logic [XLEN-1:0]          i_div_out_srcA,
  output logic                     o_div_out_done,
  output logic [XLEN-1:0]          o_div_out_result
);

  import riscv_div_pkg::*;

  localparam int WLEN = (XLEN > 32) ? 32 : XLEN;
  localparam logic [XLEN-1:0] WORD_MASK = {XLEN{1'b1}} >> (XLEN - WLEN);
  localparam logic [XLEN-1:0] ONE = {{(XLEN-1){1'b0}}, 1'b1};

  logic            rem_op;
  logic            neg;
  logic [XLEN-1:0] raw;
  logic [XLEN-1:0] raw_neg;
  logic [XLEN-1:0] full_res;
  logic [XLEN-1:0] result;

  assign rem_op = op_is_rem(i_div_out_ctrl.op);

  // ~~~~~~~~~~~~~~~~~~~~
  // pick and sign
  // ~~~~~~~~~~~~~~~~~~~~

  always_comb
  begin
    case (i_div_out_ctrl.op)
      DIV:
      begin
        // quotient is negative when exactly one operand is
        raw = i_div_out_quotient;
        neg = i_div_out_sign.a_neg ^ i_div_out_sign.b_neg;
      end
      DIVU:
      begin
        raw = i_div_out_quotient;
        neg = 1'b0;
      end
      REM:
      begin
        // remainder follows the dividend
        raw = i_div_out_remainder;
        neg = i_div_out_sign.a_neg;
      end
      REMU:
      begin
        raw = i_div_out_remainder;
        neg = 1'b0;
      end
      default:
      begin
        raw = i_div_out_quotient;
        neg = 1'b0;
      end
    endcase
  end

  assign raw_neg = ~raw + ONE;

  // ~~~~~~~~~~~~~~~~~~~~
  // special cases
  // ~~~~~~~~~~~~~~~~~~~~

  always_comb
  begin
    if (i_div_out_sign.b_zero)
    begin
      // divide by zero gives all ones, or the dividend back as remainder
      full_res = rem_op ? i_div_out_srcA : '1;
    end
    else if (i_div_out_sign.ovf)
    begin
      // the effective dividend is already the most negative value
      full_res = rem_op ? '0 : i_div_out_srcA;
    end
    else if (neg)
    begin
      full_res = raw_neg;
    end
    else
    begin
      full_res = raw;
    end
  end

  // word results are sign-extended from bit 31, unsigned ones too
  always_comb
  begin
    result = full_res;
    if (i_div_out_ctrl.isword)
    begin
      result = full_res & WORD_MASK;
      if (full_res[WLEN-1])
      begin
        result = result | ~WORD_MASK;
      end
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~
  // result register
  // ~~~~~~~~~~~~~~~~~~~~

  always_ff @(posedge i_div_out_clk, negedge i_div_out_rstn)
  begin
    if (!i_div_out_rstn)
    begin
      o_div_out_done   <= 1'b0;
      o_div_out_result <= '0;
    end
    else
    begin
      // done follows the finish strobe, so it lasts a single cycle
      o_div_out_done <= i_div_out_done;
      if (i_div_out_done)
      begin
        o_div_out_result <= result;
      end
    end
  end

endmodule

`default_nettype wire

/* verilog/riscv_core_div.sv */
`timescale 1ns/10ps
`default_nettype none

module riscv_core_div
#(
  parameter int XLEN = 64
)
(
  input  logic                     i_div_out_clk,
  input  logic                     i_div_out_rstn,
  input  logic                     i_start,
  input  riscv_div_pkg::div_ctrl_t i_ctrl,
  input  logic [XLEN-1:0]          i_src_a,
  input  logic [XLEN-1:0]          i_src_b,
  output logic                     o_busy,
  output logic                     o_done,
  output logic [XLEN-1:0]          o_result
);

  import riscv_div_pkg::*;

  localparam int CNT_W = $clog2(XLEN+1);

  logic             go;
  logic [XLEN-1:0]  dividend_mag;
  logic [XLEN-1:0]  divisor_mag;
  logic [CNT_W-1:0] iter_cnt;
  div_ctrl_t        ctrl;
  div_sign_t        sign;
  logic [XLEN-1:0]  src_a_eff;
  logic             fin;
  logic [XLEN-1:0]  quotient;
  logic [XLEN-1:0]  remainder;
  logic             done;

  // front stage, holds the request until done
  riscv_core_div_in #(.XLEN(XLEN)) div_in_i
  (
    .i_div_out_clk  (i_div_out_clk),
    .i_div_out_rstn (i_div_out_rstn),
    .i_start        (i_start),
    .i_ctrl         (i_ctrl),
    .i_src_a        (i_src_a),
    .i_src_b        (i_src_b),
    .i_done         (done),
    .o_busy         (o_busy),
    .o_go           (go),
    .o_dividend_mag (dividend_mag),
    .o_divisor_mag  (divisor_mag),
    .o_iter_cnt     (iter_cnt),
    .o_ctrl         (ctrl),
    .o_sign         (sign),
    .o_src_a_eff    (src_a_eff)
  );

  riscv_core_div_core #(.XLEN(XLEN)) div_core_i
  (
    .i_div_out_clk  (i_div_out_clk),
    .i_div_out_rstn (i_div_out_rstn),
    .i_go           (go),
    .i_dividend_mag (dividend_mag),
    .i_divisor_mag  (divisor_mag),
    .i_iter_cnt     (iter_cnt),
    .o_fin          (fin),
    .o_quotient     (quotient),
    .o_remainder    (remainder)
  );

  riscv_core_div_out #(.XLEN(XLEN)) div_out_i
  (
    .i_div_out_clk       (i_div_out_clk),
    .i_div_out_rstn      (i_div_out_rstn),
    .i_div_out_done      (fin),
    .i_div_out_quotient  (quotient),
    .i_div_out_remainder (remainder),
    .i_div_out_ctrl      (ctrl),
    .i_div_out_sign      (sign),
    .i_div_out_srcA      (src_a_eff),
    .o_div_out_done      (done),
    .o_div_out_result    (o_result)
  );

  assign o_done = done;

endmodule

`default_nettype wire

/* verif/riscv_core_div_tb.sv */
`timescale 1ns/10ps
`default_nettype none

module riscv_core_div_tb;

  import riscv_div_pkg::*;

  localparam int XLEN   = 64;
  localparam int N_RAND = 200;

  typedef struct packed
  {
    div_op_e         op;
    logic            isword;
    logic [XLEN-1:0] a;
    logic [XLEN-1:0] b;
    logic [XLEN-1:0] exp;
  } case_t;

  logic            clk;
  logic            rstn;
  logic            start;
  div_ctrl_t       ctrl;
  logic [XLEN-1:0] src_a;
  logic [XLEN-1:0] src_b;
  logic            busy;
  logic            done;
  logic [XLEN-1:0] result;

  case_t           cases[$];
  bit              table_loaded = 1'b0;
  logic [31:0]     lfsr = 32'hcc06_e951;

  riscv_core_div #(.XLEN(XLEN)) dut_i
  (
    .i_div_out_clk  (clk),
    .i_div_out_rstn (rstn),
    .i_start        (start),
    .i_ctrl         (ctrl),
    .i_src_a        (src_a),
    .i_src_b        (src_b),
    .o_busy         (busy),
    .o_done         (done),
    .o_result       (result)
  );

  initial
  begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // ~~~~~~~~~~~~~~~~~~~~
  // compare tasks
  // ~~~~~~~~~~~~~~~~~~~~

  task automatic compare_result(input string name, input logic [XLEN-1:0] exp,
                                input logic [XLEN-1:0] act);
    if (act !== exp)
    begin
      $display("Fail %s expected %h actual %h", name, exp, act);
      $display("Verification failed");
      $fatal(1, "result mismatch");
    end
  endtask

  task automatic compare_busy(input string name, input logic exp, input logic act);
    if (act !== exp)
    begin
      $display("Fail %s expected busy %b actual %b", name, exp, act);
      $display("Verification failed");
      $fatal(1, "busy mismatch");
    end
  endtask

  task automatic compare_done(input string name, input logic exp, input logic act);
    if (act !== exp)
    begin
      $display("Fail %s expected done %b actual %b", name, exp, act);
      $display("Verification failed");
      $fatal(1, "done mismatch");
    end
  endtask

  // ~~~~~~~~~~~~~~~~~~~~
  // reference model
  // ~~~~~~~~~~~~~~~~~~~~

  function automatic logic [XLEN-1:0] ref_result(input div_op_e op, input logic isword,
                                                 input logic [XLEN-1:0] a,
                                                 input logic [XLEN-1:0] b);
    logic signed [XLEN-1:0] sa;
    logic signed [XLEN-1:0] sb;
    logic [XLEN-1:0]        ua;
    logic [XLEN-1:0]        ub;
    logic [XLEN-1:0]        min_val;
    logic [XLEN-1:0]        r;
    logic                   sgn;
    logic                   rem;
    sgn = (op == DIV) || (op == REM);
    rem = (op == REM) || (op == REMU);
    ua  = a;
    ub  = b;
    sa  = a;
    sb  = b;
    min_val = {1'b1, {(XLEN-1){1'b0}}};
    if (isword)
    begin
      ua = {{(XLEN-32){1'b0}}, a[31:0]};
      ub = {{(XLEN-32){1'b0}}, b[31:0]};
      sa = {{(XLEN-32){a[31]}}, a[31:0]};
      sb = {{(XLEN-32){b[31]}}, b[31:0]};
      min_val = {{(XLEN-31){1'b1}}, 31'b0};
    end
    if (ub == '0)
      r = rem ? (sgn ? sa : ua) : '1;
    else if (sgn && (sb == '1) && (sa == min_val))
      r = rem ? '0 : min_val;
    else if (sgn)
      r = rem ? (sa % sb) : (sa / sb);
    else
      r = rem ? (ua % ub) : (ua / ub);
    if (isword)
      r = {{(XLEN-32){r[31]}}, r[31:0]};
    return r;
  endfunction

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    logic fb;
    // taps 32 22 2 1
    fb = s[31] ^ s[21] ^ s[1] ^ s[0];
    return {s[30:0], fb};
  endfunction

  task automatic draw_bits(input int n, output logic [XLEN-1:0] val);
    val = '0;
    for (int k = 0; k < n; k++)
    begin
      lfsr = lfsr_next(lfsr);
      val  = {val[XLEN-2:0], lfsr[0]};
    end
  endtask

  function automatic string op_label(input div_op_e op, input logic isword);
    return isword ? {op.name(), "W"} : op.name();
  endfunction

  // ~~~~~~~~~~~~~~~~~~~~
  // request handling
  // ~~~~~~~~~~~~~~~~~~~~

  task automatic issue(input div_op_e op, input logic isword,
                       input logic [XLEN-1:0] a, input logic [XLEN-1:0] b);
    start       = 1'b1;
    ctrl.op     = op;
    ctrl.isword = isword;
    src_a       = a;
    src_b       = b;
  endtask

  // busy has to hold until done shows up, and drop with it
  task automatic wait_done(input string name);
    while (!done)
    begin
      compare_busy(name, 1'b1, busy);
      @(posedge clk);
      #1;
    end
    compare_busy(name, 1'b0, busy);
  endtask

  task automatic run_op(input string name, input div_op_e op, input logic isword,
                        input logic [XLEN-1:0] a, input logic [XLEN-1:0] b,
                        output logic [XLEN-1:0] res);
    issue(op, isword, a, b);
    @(posedge clk);
    #1;
    start = 1'b0;
    wait_done(name);
    res = result;
    @(posedge clk);
    #1;
    compare_done({name, " done width"}, 1'b0, done);
  endtask

  task automatic add_case(input div_op_e op, input logic isword, input logic [XLEN-1:0] a,
                          input logic [XLEN-1:0] b, input logic [XLEN-1:0] exp);
    case_t c;
    c.op     = op;
    c.isword = isword;
    c.a      = a;
    c.b      = b;
    c.exp    = exp;
    cases.push_back(c);
  endtask

  // columns are op, word flag, dividend, divisor, expected result
  task automatic load_table();
    add_case(DIV,  0, 64'd20, 64'd3, 64'd6);
    add_case(DIV,  0, 64'hFFFF_FFFF_FFFF_FFEC, 64'd3, 64'hFFFF_FFFF_FFFF_FFFA);
    add_case(DIV,  0, 64'd20, 64'hFFFF_FFFF_FFFF_FFFD, 64'hFFFF_FFFF_FFFF_FFFA);
    add_case(DIV,  0, 64'hFFFF_FFFF_FFFF_FFEC, 64'hFFFF_FFFF_FFFF_FFFD, 64'd6);
    add_case(REM,  0, 64'hFFFF_FFFF_FFFF_FFEC, 64'd3, 64'hFFFF_FFFF_FFFF_FFFE);
    add_case(REM,  0, 64'd20, 64'hFFFF_FFFF_FFFF_FFFD, 64'd2);
    add_case(DIV,  0, 64'h8000_0000_0000_0001, 64'd2, 64'hC000_0000_0000_0001);
    add_case(REM,  0, 64'h8000_0000_0000_0001, 64'd2, 64'hFFFF_FFFF_FFFF_FFFF);
    add_case(DIVU, 0, 64'hFFFF_FFFF_FFFF_FFEC, 64'd3, 64'h5555_5555_5555_554E);
    add_case(REMU, 0, 64'hFFFF_FFFF_FFFF_FFEC, 64'd3, 64'd2);
    add_case(DIVU, 0, 64'd100, 64'd7, 64'd14);
    add_case(REMU, 0, 64'd100, 64'd7, 64'd2);
    // divide by zero on all eight ops
    add_case(DIV,  0, 64'hFFFF_FFFF_FFFF_FFEC, 64'd0, 64'hFFFF_FFFF_FFFF_FFFF);
    add_case(DIVU, 0, 64'd5, 64'd0, 64'hFFFF_FFFF_FFFF_FFFF);
    add_case(REM,  0, 64'hFFFF_FFFF_FFFF_FFEC, 64'd0, 64'hFFFF_FFFF_FFFF_FFEC);
    add_case(REMU, 0, 64'h1234, 64'd0, 64'h1234);
    add_case(DIV,  1, 64'hDEAD_BEEF_0000_0007, 64'hFFFF_FFFF_0000_0000, 64'hFFFF_FFFF_FFFF_FFFF);
    add_case(DIVU, 1, 64'hDEAD_BEEF_0000_0007, 64'hFFFF_FFFF_0000_0000, 64'hFFFF_FFFF_FFFF_FFFF);
    add_case(REM,  1, 64'h0000_0001_8000_0005, 64'h1234_5678_0000_0000, 64'hFFFF_FFFF_8000_0005);
    add_case(REMU, 1, 64'h0000_0001_8000_0005, 64'h1234_5678_0000_0000, 64'hFFFF_FFFF_8000_0005);
    // signed overflow
    add_case(DIV,  0, 64'h8000_0000_0000_0000, 64'hFFFF_FFFF_FFFF_FFFF, 64'h8000_0000_0000_0000);
    add_case(REM,  0, 64'h8000_0000_0000_0000, 64'hFFFF_FFFF_FFFF_FFFF, 64'd0);
    add_case(DIV,  1, 64'h1234_5678_8000_0000, 64'h0000_0000_FFFF_FFFF, 64'hFFFF_FFFF_8000_0000);
    add_case(REM,  1, 64'h1234_5678_8000_0000, 64'h0000_0000_FFFF_FFFF, 64'd0);
    // word forms ignore the upper operand bits
    add_case(DIV,  1, 64'hFFFF_FFFF_0000_0064, 64'h0000_0001_FFFF_FFF9, 64'hFFFF_FFFF_FFFF_FFF2);
    add_case(REM,  1, 64'hFFFF_FFFF_0000_0064, 64'h0000_0001_FFFF_FFF9, 64'd2);
    add_case(DIV,  1, 64'h0000_0000_FFFF_FFF0, 64'd4, 64'hFFFF_FFFF_FFFF_FFFC);
    add_case(DIVU, 1, 64'h0000_0005_FFFF_FFFE, 64'hAAAA_AAAA_0000_0001, 64'hFFFF_FFFF_FFFF_FFFE);
    add_case(REMU, 1, 64'h7777_0000_F000_0000, 64'h0000_0001_F000_0001, 64'hFFFF_FFFF_F000_0000);
    add_case(DIVU, 1, 64'hFFFF_FFFF_8000_0000, 64'hFFFF_FFFF_0000_0002, 64'h0000_0000_4000_0000);
  endtask

  initial
  begin
    wait (table_loaded);
    repeat ((cases.size() + N_RAND + 4) * (XLEN + 10) + 200) @(posedge clk);
    $display("Timeout: the done strobe never came within the expected number of cycles");
    $display("Verification failed");
    $fatal(1, "watchdog expired");
  end

  // ~~~~~~~~~~~~~~~~~~~~
  // main sequence
  // ~~~~~~~~~~~~~~~~~~~~

  initial
  begin
    logic [XLEN-1:0] a;
    logic [XLEN-1:0] b;
    logic [XLEN-1:0] bits;
    logic [XLEN-1:0] res;
    div_op_e         op;
    logic            isword;
    string           name;
    rstn  = 1'b0;
    start = 1'b0;
    ctrl  = '0;
    src_a = '0;
    src_b = '0;
    load_table();
    table_loaded = 1'b1;

    repeat (5) @(posedge clk);
    #1;
    compare_busy("busy in reset", 1'b0, busy);
    compare_done("done in reset", 1'b0, done);
    compare_result("result in reset", '0, result);
    rstn = 1'b1;
    @(posedge clk);
    #1;
    compare_busy("busy after reset", 1'b0, busy);
    compare_done("done after reset", 1'b0, done);

    foreach (cases[i])
    begin
      name = $sformatf("row %0d %s", i, op_label(cases[i].op, cases[i].isword));
      run_op(name, cases[i].op, cases[i].isword, cases[i].a, cases[i].b, res);
      compare_result(name, cases[i].exp, res);
    end

    // a start strobe while busy must be dropped
    issue(DIVU, 1'b0, 64'd1000, 64'd7);
    @(posedge clk);
    #1;
    start = 1'b0;
    repeat (3)
    begin
      @(posedge clk);
      #1;
    end
    compare_busy("busy before second start", 1'b1, busy);
    issue(REMU, 1'b0, 64'd77, 64'd5);
    @(posedge clk);
    #1;
    start = 1'b0;
    wait_done("ignored start");
    compare_result("ignored start result", 64'd142, result);
    repeat (XLEN + 5)
    begin
      @(posedge clk);
      #1;
      compare_done("no extra done", 1'b0, done);
    end

    for (int n = 0; n < N_RAND; n++)
    begin
      draw_bits(2, bits);
      op = div_op_e'(bits[1:0]);
      draw_bits(1, bits);
      isword = bits[0];
      draw_bits(XLEN, a);
      draw_bits(XLEN, b);
      draw_bits(2, bits);
      // bias some draws toward small divisors, short dividends, zero and minus one
      if (bits[1:0] == 2'd0)
        b = b >> (XLEN - 8);
      else if (bits[1:0] == 2'd1)
        a = a >> (XLEN / 2);
      else if (bits[1:0] == 2'd2)
        b = {XLEN{b[0]}};
      name = $sformatf("random %0d %s a=%h b=%h", n, op_label(op, isword), a, b);
      run_op(name, op, isword, a, b, res);
      compare_result(name, ref_result(op, isword, a, b), res);
    end

    $display("Verification passed");
    $finish;
  end

endmodule

`default_nettype wire

/* all.f */
verilog/riscv_div_pkg.sv
verilog/riscv_core_div_in.sv
verilog/riscv_core_div_core.sv
verilog/riscv_core_div_out.sv
verilog/riscv_core_div.sv
verif/riscv_core_div_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the divider testbench with Verilator
# the exit status is nonzero when the build or the simulation fails

cd "$(dirname "$0")" || exit 1

SIM_DIR=obj_dir
SIM_BIN=riscv_core_div_sim

verilator --binary --timing -Wno-fatal \
  -f all.f \
  --top-module riscv_core_div_tb \
  -Mdir "$SIM_DIR" \
  -o "$SIM_BIN"
status=$?
if [ $status -ne 0 ]; then
  echo "compile failed with status $status"
  exit $status
fi

"./$SIM_DIR/$SIM_BIN"
status=$?
if [ $status -ne 0 ]; then
  echo "simulation failed with status $status"
  exit $status
fi

echo "simulation finished"
exit 0
